// File: Makefile
VERILATOR ?= verilator
TOP       ?= risc_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***
SOURCES   := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/risc_assert.sv
`include "risc_config.svh"

module risc_assert (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    step,
	input risc_pkg::ctrl_state_t   state,
	input logic                    dump_mem,
	input logic                    cpu_we,
	input logic                    load_en,
	input risc_pkg::word_t         shown_addr,
	input risc_pkg::word_t         rdata,
	input logic [`RISC_DIGITS-1:0] anode
);
	import risc_pkg::*;

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	// At most one digit lit, all dark until the first scan tick
	a_one_anode: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~anode) <= 1)
		else begin
			fail_count++;
			$error("More than one anode is active");
		end

	// Only reset brings the processor out of HALTED
	a_halt_sticks: assert property (@(posedge clk) disable iff (!rst_n)
		state == HALTED |=> state == HALTED)
		else begin
			fail_count++;
			$error("HALTED was left without reset");
		end

	// The control FSM moves only on a step strobe
	a_step_only: assert property (@(posedge clk) disable iff (!rst_n)
		!step |=> $stable(state))
		else begin
			fail_count++;
			$error("Control state changed without a step");
		end

	// The viewer owns the port, so a processor store must leave the word as it was
	// The word read back after the store has to match the word read before it
	a_no_write_in_dump: assert property (@(posedge clk) disable iff (!rst_n)
		dump_mem && cpu_we && !load_en ##1 $stable(shown_addr) |=> $stable(rdata))
		else begin
			fail_count++;
			$error("Memory was written by the processor while the dump is active");
		end

endmodule

bind risc_system risc_assert u_assert (
	.clk(clk), .rst_n(rst_n), .step(step), .state(state), .dump_mem(dump_mem),
	.cpu_we(cpu_we), .load_en(load_en), .shown_addr(shown_addr), .rdata(shown_data),
	.anode(anode)
);

// File: bench/risc_tb.sv
`include "risc_config.svh"

module risc_tb;
	import risc_pkg::*;

	localparam int DIGITS = `RISC_DIGITS;

	logic              clk;
	logic              rst_n;
	logic              step;
	logic              load_en;
	mem_addr_t         load_addr;
	word_t             load_data;
	logic              dump_mem;
	logic              view_step;
	logic              view_clear;
	status_t           status;
	word_t             shown_addr;
	word_t             shown_data;
	seg_t              seg;
	logic [DIGITS-1:0] anode;

	int               fd;
	int               n_read;
	int               line_count = 0;
	int               watchdog_clocks = 0;
	logic [7:0]       cmd;
	logic [8*32-1:0]  test_name;
	logic [8*128-1:0] line_buf;
	logic [31:0]      arg_a;
	logic [31:0]      arg_b;
	word_t            last_addr;
	word_t            last_data;

	risc_system i_dut (
		.clk(clk), .rst_n(rst_n), .step(step), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .dump_mem(dump_mem), .view_step(view_step),
		.view_clear(view_clear), .status(status), .shown_addr(shown_addr),
		.shown_data(shown_data), .seg(seg), .anode(anode)
	);

	always #2 clk = ~clk;

	// Inputs change one time unit after the rising edge, outputs are read there too
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run(input string reason);
		$display("%0s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED %0s: %0s expected %h actual %h",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_status(input status_t exp, input status_t act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED %0s: status expected %h actual %h",
				test_name, exp, act));
		end
	endtask

	task automatic check_seg(input seg_t exp_seg, input logic [DIGITS-1:0] exp_anode,
		input seg_t act_seg, input logic [DIGITS-1:0] act_anode);
		if (act_seg !== exp_seg || act_anode !== exp_anode) begin
			abort_run($sformatf("CHECK FAILED %0s: seg/anode expected %h/%b actual %h/%b",
				test_name, exp_seg, exp_anode, act_seg, act_anode));
		end
	endtask

	// Common-anode hex font, bit 6 is segment a, a low bit lights the segment
	function automatic seg_t hex_font(input nibble_t value);
		case (value)
			4'h0: return 7'b0000001;
			4'h1: return 7'b1001111;
			4'h2: return 7'b0010010;
			4'h3: return 7'b0000110;
			4'h4: return 7'b1001100;
			4'h5: return 7'b0100100;
			4'h6: return 7'b0100000;
			4'h7: return 7'b0001111;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0000100;
			4'hA: return 7'b0001000;
			4'hB: return 7'b1100000;
			4'hC: return 7'b0110001;
			4'hD: return 7'b1000010;
			4'hE: return 7'b0110000;
			default: return 7'b0111000;
		endcase
	endfunction

	// Every test starts from a clean processor, memory keeps its contents
	task automatic reset_dut();
		rst_n = 1'b0;
		step = 1'b0;
		load_en = 1'b0;
		dump_mem = 1'b0;
		view_step = 1'b0;
		view_clear = 1'b0;
		repeat (16) next_cycle();
		rst_n = 1'b1;
		check_status(status_t'(8'h00), status);
		check_word("shown_addr after reset", '0, shown_addr);
	endtask

	task automatic load_word(input mem_addr_t addr, input word_t data);
		load_en = 1'b1;
		load_addr = addr;
		load_data = data;
		next_cycle();
		load_en = 1'b0;
	endtask

	// One step strobe every third clock until the processor halts
	task automatic run_program();
		dump_mem = 1'b0;
		while (!status.halted) begin
			step = 1'b1;
			next_cycle();
			step = 1'b0;
			repeat (2) next_cycle();
		end
	endtask

	// Walk the viewer from zero up to addr, checking each address on the way
	task automatic check_memory(input mem_addr_t addr, input word_t exp);
		mem_addr_t count;
		dump_mem = 1'b1;
		view_clear = 1'b1;
		next_cycle();
		view_clear = 1'b0;
		count = '0;
		check_word("view address after clear", '0, shown_addr);
		while (count != addr) begin
			view_step = 1'b1;
			next_cycle();
			view_step = 1'b0;
			count = count + 1'b1;
			check_word("view address", word_t'(count), shown_addr);
		end
		// Read data follows its address by one clock
		next_cycle();
		check_word("dumped word", exp, shown_data);
		last_addr = word_t'(addr);
		last_data = exp;
	endtask

	// One full scan of the word shown by the last dump
	task automatic check_display();
		logic [DIGITS*4-1:0] digits;
		logic [DIGITS-1:0]   prev;
		logic [DIGITS-1:0]   exp_anode;
		int                  start;
		int                  idx;
		digits = {last_addr, last_data};
		prev = anode;
		next_cycle();
		// Line up with a digit change so each digit gets its full slot
		while (anode == prev) begin
			next_cycle();
		end
		start = -1;
		for (int d = 0; d < DIGITS; d++) begin
			exp_anode = '1;
			exp_anode[d] = 1'b0;
			if (anode == exp_anode) begin
				start = d;
			end
		end
		if (start < 0) begin
			abort_run($sformatf("Display in %0s shows anode pattern %b, not one active digit",
				test_name, anode));
		end
		for (int k = 0; k < DIGITS; k++) begin
			idx = (start + k) % DIGITS;
			exp_anode = '1;
			exp_anode[idx] = 1'b0;
			for (int j = 0; j < `RISC_SCAN_DIV; j++) begin
				check_seg(hex_font(digits[idx*4 +: 4]), exp_anode, seg, anode);
				next_cycle();
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		step = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		dump_mem = 1'b0;
		view_step = 1'b0;
		view_clear = 1'b0;
		test_name = "none";
		last_addr = '0;
		last_data = '0;
		// First pass only sizes the watchdog
		fd = $fopen("bench/risc_tests.txt", "r");
		if (fd == 0) begin
			abort_run("The test data file bench/risc_tests.txt could not be opened");
		end
		while (!$feof(fd)) begin
			if ($fgets(line_buf, fd) > 0) begin
				line_count++;
			end
		end
		$fclose(fd);
		watchdog_clocks = 200 * line_count + 4000;
		fd = $fopen("bench/risc_tests.txt", "r");
		while (!$feof(fd)) begin
			n_read = $fscanf(fd, "%s", cmd);
			if (n_read == 1) begin
				if (cmd == "#") begin
					n_read = $fgets(line_buf, fd);
				end else if (cmd == "T") begin
					n_read = $fscanf(fd, "%s", test_name);
					reset_dut();
				end else if (cmd == "L") begin
					n_read = $fscanf(fd, "%h %h", arg_a, arg_b);
					load_word(mem_addr_t'(arg_a), word_t'(arg_b));
				end else if (cmd == "R") begin
					run_program();
				end else if (cmd == "S") begin
					n_read = $fscanf(fd, "%h", arg_a);
					check_status(status_t'(arg_a[7:0]), status);
				end else if (cmd == "M") begin
					n_read = $fscanf(fd, "%h %h", arg_a, arg_b);
					check_memory(mem_addr_t'(arg_a), word_t'(arg_b));
				end else if (cmd == "D") begin
					check_display();
				end else begin
					abort_run($sformatf("Unknown command %s in the test data file", cmd));
				end
			end
		end
		$fclose(fd);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Watch the bound checker for a failed assertion
	always @(posedge clk) begin
		if (i_dut.u_assert.fail_count != 0) begin
			abort_run("An assertion in the bound checker failed");
		end
	end

	// Budget grows with the length of the data file
	initial begin
		wait (watchdog_clocks > 0);
		repeat (watchdog_clocks) @(posedge clk);
		$display("Timeout after %0d clocks, the tests did not finish", watchdog_clocks);
		$display("*** TEST FAILED ***");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: bench/risc_tests.txt
# Columns: T name | L addr data | R | S status | M addr data | D, values in hex
# S status packs {halted, carry, negative, zero, state[3:0]}, HALTED is state 6
T alu_flags
L 00 715A
L 01 72F0
L 02 0312
L 03 9330
L 04 1412
L 05 9440
L 06 2512
L 07 9550
L 08 3612
L 09 9610
L 0A 4712
L 0B 9770
L 0C 4811
L 0D F000
R
S 96
M 4A 014A
M 6A FF6A
M 50 0050
M 5A 00FA
M AA 00AA
D
T copy_loop_shift
L 30 BEEF
L 00 7130
L 01 8210
L 02 7331
L 03 9230
L 04 7403
L 05 7501
L 06 0775
L 07 1445
L 08 A00A
L 09 B006
L 0A 7632
L 0B 9760
L 0C 6A20
L 0D 5920
L 0E 9990
L 0F 9AA0
L 10 F000
R
S C6
M 30 BEEF
M 31 BEEF
M 32 0003
M 77 5F77
M DE 7DDE
D

// File: logic/display_scan.sv
`include "risc_config.svh"

module display_scan (
	input  logic                    clk,
	input  logic                    rst_n,
	input  risc_pkg::word_t         shown_addr,
	input  risc_pkg::word_t         shown_data,
	output risc_pkg::seg_t          seg,
	output logic [`RISC_DIGITS-1:0] anode
);
	import risc_pkg::*;

	logic [$clog2(`RISC_SCAN_DIV)-1:0] div_cnt;
	logic [$clog2(`RISC_DIGITS)-1:0]   digit;
	logic [$clog2(`RISC_DIGITS)-1:0]   digit_next;
	logic [`RISC_DIGITS-1:0]           digit_onehot;
	logic [`RISC_DIGITS*4-1:0]         all_digits;
	logic                              tick;
	nibble_t                           nibble;

	// Address fills the upper four digits, data the lower four
	assign all_digits = {shown_addr, shown_data};
	assign nibble     = all_digits[digit*4 +: 4];

	assign tick       = (div_cnt == `RISC_SCAN_DIV - 1);
	assign digit_next = digit + 1'b1;

	always_comb begin
		digit_onehot             = '0;
		digit_onehot[digit_next] = 1'b1;
	end

	// Anodes stay dark until the first tick, then follow the digit counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			digit   <= '0;
			anode   <= '1;
		end else if (tick) begin
			div_cnt <= '0;
			digit   <= digit_next;
			anode   <= ~digit_onehot;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Hex font, segments a to g, a zero lights the segment
	always_comb begin
		case (nibble)
			4'h0: seg = 7'h01;
			4'h1: seg = 7'h4F;
			4'h2: seg = 7'h12;
			4'h3: seg = 7'h06;
			4'h4: seg = 7'h4C;
			4'h5: seg = 7'h24;
			4'h6: seg = 7'h20;
			4'h7: seg = 7'h0F;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h04;
			4'hA: seg = 7'h08;
			4'hB: seg = 7'h60;
			4'hC: seg = 7'h31;
			4'hD: seg = 7'h42;
			4'hE: seg = 7'h30;
			default: seg = 7'h38;
		endcase
	end

endmodule

// File: logic/memory_port.sv
`include "risc_config.svh"

module memory_port (
	input  logic                clk,
	input  logic                rst_n,
	input  risc_pkg::mem_addr_t cpu_addr,
	input  risc_pkg::word_t     cpu_wdata,
	input  logic                cpu_we,
	input  logic                load_en,
	input  risc_pkg::mem_addr_t load_addr,
	input  risc_pkg::word_t     load_data,
	input  logic                dump_mem,
	input  logic                view_step,
	input  logic                view_clear,
	output risc_pkg::word_t     rdata,
	output risc_pkg::word_t     shown_addr
);
	import risc_pkg::*;

	word_t     mem [`RISC_MEM_DEPTH];
	mem_addr_t view_cnt;
	mem_addr_t port_addr;
	logic      mem_we;

	// Viewer counter, wraps from the last word back to zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			view_cnt <= '0;
		end else if (view_clear) begin
			view_cnt <= '0;
		end else if (view_step) begin
			view_cnt <= view_cnt + 1'b1;
		end
	end

	// In dump mode the viewer owns the address
	assign port_addr = dump_mem ? view_cnt : cpu_addr;

	// Processor stores are dropped while the viewer holds the port
	assign mem_we = cpu_we && !dump_mem;

	// Display shows the port address widened to a full word
	assign shown_addr = word_t'(port_addr);

	// Synchronous array; a read returns the old word on a same-cycle write
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end else if (mem_we) begin
			mem[port_addr] <= cpu_wdata;
		end
		rdata <= mem[port_addr];
	end

endmodule

// File: logic/risc_config.svh
`ifndef RISC_CONFIG_SVH
`define RISC_CONFIG_SVH

// Width of a data word and of one instruction
`define RISC_WORD_W 16

// Size of the general purpose register file
`define RISC_REG_COUNT 16

// Number of words in the shared memory, addressed by eight bits
`define RISC_MEM_DEPTH 256

// Seven-segment digits on the display, address on the left half
`define RISC_DIGITS 8

// Clocks each digit stays lit before the scan moves on
`define RISC_SCAN_DIV 4

`endif

// File: logic/risc_control.sv
module risc_control (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  step,
	input  risc_pkg::opcode_t     opcode,
	input  logic                  zero,
	output risc_pkg::ctrl_t       ctrl,
	output risc_pkg::ctrl_state_t state
);
	import risc_pkg::*;

	ctrl_state_t state_next;
	logic        is_alu;
	logic        is_reg_wb;

	// Operations that go through the ALU and update the flags
	assign is_alu = opcode inside {ADD, SUB, AND, OR, XOR, SHL, SHR};

	// LDI writes a register too, but it leaves the flags alone
	assign is_reg_wb = is_alu || (opcode == LDI);

	// One state per step strobe, nothing moves between strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FETCH;
		end else if (step) begin
			state <= state_next;
		end
	end

	// The opcode is only valid from EXECUTE on, after DECODE has filled the IR
	always_comb begin
		state_next = state;
		case (state)
			FETCH: begin
				state_next = DECODE;
			end
			DECODE: begin
				state_next = EXECUTE;
			end
			EXECUTE: begin
				if (is_reg_wb || opcode == JZ || opcode == JMP) begin
					state_next = WRITEBACK;
				end else if (opcode == LD) begin
					state_next = MEM_READ;
				end else if (opcode == ST) begin
					state_next = MEM_WRITE;
				end else begin
					// HALT and the unused codes stop here
					state_next = HALTED;
				end
			end
			MEM_READ: begin
				state_next = WRITEBACK;
			end
			MEM_WRITE: begin
				state_next = FETCH;
			end
			WRITEBACK: begin
				state_next = FETCH;
			end
			HALTED: begin
				state_next = HALTED;
			end
			default: begin
				state_next = FETCH;
			end
		endcase
	end

	// Strobes per state; the execution unit qualifies each one with step
	always_comb begin
		ctrl = '0;
		case (state)
			DECODE: begin
				// Memory has held the word at PC since FETCH, so take it now
				ctrl.ir_load = 1'b1;
				ctrl.pc_inc  = 1'b1;
			end
			EXECUTE: begin
				ctrl.alu_to_flags = is_alu;
			end
			MEM_READ: begin
				ctrl.addr_from_reg = 1'b1;
			end
			MEM_WRITE: begin
				// the write itself happens on the step leaving this state
				ctrl.addr_from_reg = 1'b1;
			end
			WRITEBACK: begin
				if (opcode == LD) begin
					// Keep the load address so the read data stays put
					ctrl.addr_from_reg = 1'b1;
					ctrl.wb_from_mem   = 1'b1;
					ctrl.reg_write     = 1'b1;
				end else if (is_reg_wb) begin
					ctrl.reg_write = 1'b1;
				end else if (opcode == JMP) begin
					ctrl.pc_jump = 1'b1;
				end else if (opcode == JZ) begin
					ctrl.pc_jump = zero;
				end
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: logic/risc_datapath.sv
`include "risc_config.svh"

module risc_datapath (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                step,
	input  risc_pkg::ctrl_t     ctrl,
	input  risc_pkg::word_t     mem_rdata,
	output risc_pkg::opcode_t   opcode,
	output logic                zero,
	output risc_pkg::mem_addr_t mem_addr,
	output risc_pkg::word_t     mem_wdata,
	output logic                mem_we,
	output logic [2:0]          flags
);
	import risc_pkg::*;

	mem_addr_t             pc;
	instr_t                ir;
	word_t                 regs [`RISC_REG_COUNT];
	logic                  carry_q;
	logic                  negative_q;
	logic                  zero_q;
	word_t                 op_a;
	word_t                 op_b;
	mem_addr_t             imm;
	logic [$bits(word_t):0] sum;
	logic [$bits(word_t):0] diff;
	word_t                 alu_y;
	logic                  alu_c;
	word_t                 wb_data;

	// Operands are rs and rt, the result always goes to rd
	assign op_a = regs[ir.rs];
	assign op_b = regs[ir.rt];
	assign imm  = {ir.rs, ir.rt};

	// Bit 16 of the difference is set exactly when a borrow occurs
	assign sum  = {1'b0, op_a} + {1'b0, op_b};
	assign diff = {1'b0, op_a} - {1'b0, op_b};

	always_comb begin
		alu_y = '0;
		alu_c = 1'b0;
		case (ir.opcode)
			ADD: {alu_c, alu_y} = sum;
			SUB: {alu_c, alu_y} = diff;
			AND: alu_y = op_a & op_b;
			OR:  alu_y = op_a | op_b;
			XOR: alu_y = op_a ^ op_b;
			// Shifts move one bit and carry out the bit that falls off
			SHL: {alu_c, alu_y} = {op_a, 1'b0};
			SHR: {alu_y, alu_c} = {1'b0, op_a};
			LDI: alu_y = word_t'(imm);
			default: alu_y = '0;
		endcase
	end

	assign wb_data = ctrl.wb_from_mem ? mem_rdata : alu_y;

	// LD and ST use the low byte of rs as the memory address
	assign mem_addr  = ctrl.addr_from_reg ? op_a[$bits(mem_addr_t)-1:0] : pc;
	assign mem_wdata = regs[ir.rd];
	assign mem_we    = step && ctrl.addr_from_reg && (ir.opcode == ST);

	assign opcode = ir.opcode;
	assign zero   = zero_q;
	assign flags  = {carry_q, negative_q, zero_q};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc         <= '0;
			ir         <= '0;
			carry_q    <= 1'b0;
			negative_q <= 1'b0;
			zero_q     <= 1'b0;
		end else if (step) begin
			if (ctrl.ir_load) begin
				ir <= instr_t'(mem_rdata);
			end
			// A taken jump wins over the increment
			if (ctrl.pc_jump) begin
				pc <= imm;
			end else if (ctrl.pc_inc) begin
				pc <= pc + 1'b1;
			end
			if (ctrl.alu_to_flags) begin
				carry_q    <= alu_c;
				negative_q <= alu_y[$bits(word_t)-1];
				zero_q     <= (alu_y == '0);
			end
		end
	end

	// Register file, cleared so programs start from known values
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RISC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (step && ctrl.reg_write) begin
			regs[ir.rd] <= wb_data;
		end
	end

endmodule

// File: logic/risc_pkg.sv
`include "risc_config.svh"

package risc_pkg;

	// Plain vectors for the widths that mean something in the design
	typedef logic [`RISC_WORD_W-1:0] word_t;
	typedef logic [$clog2(`RISC_MEM_DEPTH)-1:0] mem_addr_t;
	typedef logic [$clog2(`RISC_REG_COUNT)-1:0] reg_idx_t;
	typedef logic [3:0] nibble_t;

	// Active-low segments with bit 6 as segment a and bit 0 as segment g
	typedef logic [6:0] seg_t;

	// Codes C to E are unused and end the program like HALT
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		SHL  = 4'h5,
		SHR  = 4'h6,
		LDI  = 4'h7,
		LD   = 4'h8,
		ST   = 4'h9,
		JZ   = 4'hA,
		JMP  = 4'hB,
		HALT = 4'hF
	} opcode_t;

	// FETCH is code zero so a cleared status shows a processor at rest
	typedef enum logic [3:0] {
		FETCH     = 4'h0,
		DECODE    = 4'h1,
		EXECUTE   = 4'h2,
		MEM_READ  = 4'h3,
		MEM_WRITE = 4'h4,
		WRITEBACK = 4'h5,
		HALTED    = 4'h6
	} ctrl_state_t;

	// The low byte {rs, rt} doubles as imm8 for LDI and the jumps
	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
	} instr_t;

	// Levels held for a whole control state and acted on at the step strobe
	typedef struct packed {
		logic ir_load;
		logic pc_inc;
		logic pc_jump;
		logic reg_write;
		logic wb_from_mem;
		logic alu_to_flags;
		logic addr_from_reg;
	} ctrl_t;

	// Eight status LEDs, halted on the left and the state code on the right
	typedef struct packed {
		logic        halted;
		logic        carry;
		logic        negative;
		logic        zero;
		ctrl_state_t state;
	} status_t;

endpackage

// File: logic/risc_system.sv
`include "risc_config.svh"

module risc_system (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    step,
	input  logic                    load_en,
	input  risc_pkg::mem_addr_t     load_addr,
	input  risc_pkg::word_t         load_data,
	input  logic                    dump_mem,
	input  logic                    view_step,
	input  logic                    view_clear,
	output risc_pkg::status_t       status,
	output risc_pkg::word_t         shown_addr,
	output risc_pkg::word_t         shown_data,
	output risc_pkg::seg_t          seg,
	output logic [`RISC_DIGITS-1:0] anode
);
	import risc_pkg::*;

	ctrl_t       ctrl;
	ctrl_state_t state;
	opcode_t     opcode;
	logic        zero;
	mem_addr_t   cpu_addr;
	word_t       cpu_wdata;
	logic        cpu_we;
	logic [2:0]  flags;

	// flags arrive as {carry, negative, zero}
	assign status = '{
		halted:   (state == HALTED),
		carry:    flags[2],
		negative: flags[1],
		zero:     flags[0],
		state:    state
	};

	risc_control u_control (
		.clk(clk), .rst_n(rst_n), .step(step), .opcode(opcode), .zero(zero),
		.ctrl(ctrl), .state(state)
	);

	risc_datapath u_datapath (
		.clk(clk), .rst_n(rst_n), .step(step), .ctrl(ctrl), .mem_rdata(shown_data),
		.opcode(opcode), .zero(zero), .mem_addr(cpu_addr), .mem_wdata(cpu_wdata),
		.mem_we(cpu_we), .flags(flags)
	);

	// Read data feeds both the processor and the right half of the display
	memory_port u_memory (
		.clk(clk), .rst_n(rst_n), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_we(cpu_we), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .dump_mem(dump_mem), .view_step(view_step),
		.view_clear(view_clear), .rdata(shown_data), .shown_addr(shown_addr)
	);

	display_scan u_display (
		.clk(clk), .rst_n(rst_n), .shown_addr(shown_addr), .shown_data(shown_data),
		.seg(seg), .anode(anode)
	);

endmodule

// File: sources.f
+incdir+logic
logic/risc_pkg.sv
logic/risc_control.sv
logic/risc_datapath.sv
logic/memory_port.sv
logic/display_scan.sv
logic/risc_system.sv
bench/risc_assert.sv
bench/risc_tb.sv
